// File: Bender.yml
package:
  name: flash_ctrl

sources:
  - source/flash_spi_pkg.sv
  - source/flash_bus_pkg.sv
  - source/flash_request_decode.sv
  - source/flash_frame_sequencer.sv
  - source/flash_mosi_shifter.sv
  - source/flash_miso_capture.sv
  - source/flash_ctrl.sv
  - target: simulation
    files:
      - sim/flash_ctrl_asserts.sv
      - sim/flash_ctrl_tb.sv

// File: sim/flash_ctrl_asserts.sv
// Protocol assertions for the serial flash read controller
// Bound into the top level, watches the pins and the bus handshake

`timescale 1ns/1ps

module flash_ctrl_asserts
(
	input logic i_clk,
	input logic i_reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input logic i_wb_stall,
	input logic i_wb_ack,
	input logic i_user_mode,
	input logic i_cs_n,
	input logic i_sck
);

	// Number of failed assertions so far
	int fail_count = 0;

	// Serial clock only runs with the flash selected
	a_sck_selected: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_sck && i_cs_n))
		else
		begin
			fail_count++;
			$error("Serial clock high while chip select is high");
		end

	// Single cycle ack
	a_ack_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
		i_wb_ack |=> !i_wb_ack)
		else
		begin
			fail_count++;
			$error("Bus ack held for more than one cycle");
		end

	// Full read frame, ack seen on the 66th edge after the accepting edge
	a_read_ack: assert property (@(posedge i_clk) disable iff (i_reset || !i_wb_cyc)
		(i_wb_stb && !i_wb_we && !i_wb_stall && !i_user_mode) |-> ##66 i_wb_ack)
		else
		begin
			fail_count++;
			$error("Read ack missing at the end of the frame");
		end

endmodule

bind flash_ctrl flash_ctrl_asserts u_asserts (
	.i_clk       (i_clk),
	.i_reset     (i_reset),
	.i_wb_cyc    (i_wb_cyc),
	.i_wb_stb    (i_wb_stb),
	.i_wb_we     (i_wb_we),
	.i_wb_stall  (o_wb_stall),
	.i_wb_ack    (o_wb_ack),
	.i_user_mode (user_mode),
	.i_cs_n      (cs_n),
	.i_sck       (sck)
);

// File: sim/flash_ctrl_tb.sv
// Testbench for the serial flash read controller
// Serial flash model, reference results and directed bus traffic

`timescale 1ns/1ps

module flash_ctrl_tb import flash_spi_pkg::*, flash_bus_pkg::*;
();

	localparam time CLK_PERIOD = 40ns;
	localparam time DRIVE_DELAY = 2ns;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = 200;
	localparam spi_pins_t PINS_IDLE = '{cs_n: 1'b1, sck: 1'b0, mosi: 1'b0};
	localparam spi_pins_t PINS_USER = '{cs_n: 1'b0, sck: 1'b0, mosi: 1'b0};

	logic i_clk;
	logic i_reset;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_cfg_stb;
	logic i_wb_we;
	logic [WORD_ADDR_W-1:0] i_wb_addr;
	logic [DATA_W-1:0] i_wb_data;
	logic o_wb_stall;
	logic o_wb_ack;
	logic [DATA_W-1:0] o_wb_data;
	spi_pins_t o_spi;
	logic i_spi_miso;

	integer seed;
	// Flash contents and what the model saw on the pins
	logic [DATA_W-1:0] mem [0:255];
	logic [7:0] rx_opcode;
	logic [23:0] rx_addr;
	logic [7:0] rx_byte;
	logic pin_sck;
	int bit_idx;
	int sck_cycles;

	flash_ctrl dut (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_wb_cyc   (i_wb_cyc),
		.i_wb_stb   (i_wb_stb),
		.i_cfg_stb  (i_cfg_stb),
		.i_wb_we    (i_wb_we),
		.i_wb_addr  (i_wb_addr),
		.i_wb_data  (i_wb_data),
		.o_wb_stall (o_wb_stall),
		.o_wb_ack   (o_wb_ack),
		.o_wb_data  (o_wb_data),
		.o_spi      (o_spi),
		.i_spi_miso (i_spi_miso)
	);

	always #(CLK_PERIOD / 2) i_clk = !i_clk;

	////////////////////
	// Serial flash model
	////////////////////

	// The pin clock lags the controller's sck by one cycle
	// Opcode and address bits are echoed back inverted, so a user byte returns its complement
	always @(posedge i_clk)
	begin
		#(DRIVE_DELAY);
		if (o_spi.cs_n !== 1'b0)
			bit_idx = 0;
		else if (pin_sck)
		begin
			sck_cycles = sck_cycles + 1;
			rx_byte = {rx_byte[6:0], o_spi.mosi};
			if (bit_idx < 8)
				rx_opcode = {rx_opcode[6:0], o_spi.mosi};
			else if (bit_idx < 32)
				rx_addr = {rx_addr[22:0], o_spi.mosi};
			// Data word goes out top bit first after the address
			if ((bit_idx >= 32) && (rx_opcode == CMD_READ))
				i_spi_miso = mem[rx_addr[9:2]][63 - bit_idx];
			else
				i_spi_miso = !o_spi.mosi;
			bit_idx = bit_idx + 1;
		end
		pin_sck = (o_spi.sck === 1'b1);
	end

	////////////////////
	// Reference and checks
	////////////////////

	// Memory word for a word address, or the control image around the echoed byte
	function automatic logic [DATA_W-1:0] expected_result(input logic ctrl,
		input logic [WORD_ADDR_W-1:0] word_addr, input logic [7:0] sent_byte);
		logic [DATA_W-1:0] result;
		if (ctrl)
		begin
			result = '0;
			result[CTRL_FLAG_BIT] = 1'b1;
			result[7:0] = ~sent_byte;
		end
		else
			result = mem[word_addr[7:0]];
		return result;
	endfunction

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
		if (actual !== expected)
			stop_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_pins(input string name, input spi_pins_t expected);
		if (o_spi !== expected)
			stop_run($sformatf("FAIL %s expected %b actual %b", name, expected, o_spi));
	endtask

	task automatic check_byte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
			stop_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic check_latency(input string name, input int expected, input int actual);
		if (actual != expected)
			stop_run($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
	endtask

	// Any failed protocol assertion ends the run
	always @(dut.u_asserts.fail_count)
	begin
		if (dut.u_asserts.fail_count != 0)
			stop_run("A protocol assertion on the pins or the bus failed");
	end

	////////////////////
	// Bus driving
	////////////////////

	// Holds the strobe until stall is low, then drops it after the accepting edge
	task automatic wait_accept();
		int n;
		n = 0;
		@(negedge i_clk);
		while (o_wb_stall)
		begin
			n = n + 1;
			if (n > TIMEOUT_CYCLES)
				stop_run("Timed out waiting for the controller to accept a strobe");
			@(negedge i_clk);
		end
		@(posedge i_clk);
		#(DRIVE_DELAY);
		i_wb_stb = 1'b0;
		i_cfg_stb = 1'b0;
	endtask

	// Counts cycles from the accepting edge to the ack
	task automatic wait_ack(output int latency, output logic [DATA_W-1:0] rdata);
		latency = 1;
		@(negedge i_clk);
		while (!o_wb_ack)
		begin
			latency = latency + 1;
			if (latency > TIMEOUT_CYCLES)
				stop_run("Timed out waiting for the bus ack");
			@(negedge i_clk);
		end
		rdata = o_wb_data;
	endtask

	task automatic bus_transfer(input logic use_cfg, input logic we,
		input logic [WORD_ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
		output logic [DATA_W-1:0] rdata, output int latency);
		@(posedge i_clk);
		#(DRIVE_DELAY);
		i_wb_cyc = 1'b1;
		i_wb_stb = !use_cfg;
		i_cfg_stb = use_cfg;
		i_wb_we = we;
		i_wb_addr = addr;
		i_wb_data = wdata;
		wait_accept();
		wait_ack(latency, rdata);
		@(posedge i_clk);
		#(DRIVE_DELAY);
		i_wb_cyc = 1'b0;
	endtask

	// Memory read, checked against the reference and the model's view of the frame
	task automatic checked_read(input string name, input logic [WORD_ADDR_W-1:0] addr);
		logic [DATA_W-1:0] rdata;
		int latency;
		bus_transfer(1'b0, 1'b0, addr, '0, rdata, latency);
		check_word(name, expected_result(1'b0, addr, 8'h00), rdata);
		check_byte("read opcode", CMD_READ, rx_opcode);
		check_word("read address", {8'h00, addr, 2'b00}, {8'h00, rx_addr});
		check_pins("pins after read", PINS_IDLE);
	endtask

	// Drops the bus cycle in the middle of a read frame
	task automatic aborted_read(input logic [WORD_ADDR_W-1:0] addr);
		@(posedge i_clk);
		#(DRIVE_DELAY);
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we = 1'b0;
		i_wb_addr = addr;
		wait_accept();
		repeat (20) @(posedge i_clk);
		#(DRIVE_DELAY);
		i_wb_cyc = 1'b0;
		for (int n = 0; n < 80; n++)
		begin
			@(negedge i_clk);
			if (o_wb_ack)
				stop_run("Bus ack arrived after the bus cycle was dropped");
		end
		check_pins("pins after abort", PINS_IDLE);
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial
	begin
		logic [DATA_W-1:0] rdata;
		logic [WORD_ADDR_W-1:0] addr;
		int latency;
		int sck_before;

		seed = 69;
		for (int i = 0; i < 256; i++)
			mem[i] = $random(seed);
		i_clk = 1'b0;
		i_reset = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_cfg_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_addr = '0;
		i_wb_data = '0;
		i_spi_miso = 1'b0;
		pin_sck = 1'b0;
		bit_idx = 0;
		sck_cycles = 0;
		repeat (RESET_CYCLES) @(posedge i_clk);
		#(DRIVE_DELAY);
		i_reset = 1'b0;
		check_pins("pins after reset", PINS_IDLE);

		// Random reads
		for (int i = 0; i < 20; i++)
		begin
			addr = $random(seed);
			checked_read("random read", addr);
		end

		// Memory write gets an immediate ack and no frame
		sck_before = sck_cycles;
		bus_transfer(1'b0, 1'b1, 22'h0000a5, 32'hcafe_f00d, rdata, latency);
		check_latency("write ack latency", 1, latency);
		if (sck_cycles != sck_before)
			stop_run("Serial clock ran during a memory write");
		check_pins("pins after write", PINS_IDLE);

		// User byte out, then read back the echoed byte
		bus_transfer(1'b1, 1'b1, '0, 32'h0000_00a5, rdata, latency);
		check_byte("user byte at flash", 8'ha5, rx_byte);
		check_pins("pins in user mode", PINS_USER);
		bus_transfer(1'b1, 1'b0, '0, '0, rdata, latency);
		check_word("control read", expected_result(1'b1, '0, 8'ha5), rdata);

		// Memory read in user mode answers with the control image
		sck_before = sck_cycles;
		addr = $random(seed);
		bus_transfer(1'b0, 1'b0, addr, '0, rdata, latency);
		check_latency("user mode read latency", 1, latency);
		check_word("user mode read", expected_result(1'b1, '0, 8'ha5), rdata);
		if (sck_cycles != sck_before)
			stop_run("Serial clock ran during a memory read in user mode");
		check_pins("pins in user mode", PINS_USER);

		// Release, then normal reads again
		bus_transfer(1'b1, 1'b1, '0, 32'h0000_0100, rdata, latency);
		check_pins("pins after release", PINS_IDLE);
		addr = $random(seed);
		checked_read("read after release", addr);

		// Abort, then a clean read
		addr = $random(seed);
		aborted_read(addr);
		addr = $random(seed);
		checked_read("read after abort", addr);

		$display("Simulation passed");
		$finish;
	end

endmodule

// File: source/flash_bus_pkg.sv
// Bus side definitions for the flash read controller
// Widths, control register layout and the decoded request

package flash_bus_pkg;

	////////////////////
	// Bus widths
	////////////////////

	// Word address, so a 16 MB part is fully covered
	localparam int WORD_ADDR_W = 22;
	localparam int DATA_W = 32;
	// Byte exchanged in user mode
	localparam int USER_BYTE_W = 8;

	////////////////////
	// Control register
	////////////////////

	// Write side
	//   [8]    set to release user mode and raise chip select
	//   [7:0]  byte to send when bit 8 is clear
	localparam int CTRL_CS_BIT = 8;

	// Read side
	//   [12]   always reads as one
	//   [7:0]  last byte received from the flash
	localparam int CTRL_FLAG_BIT = 12;

	////////////////////
	// Decoded request
	////////////////////

	typedef enum logic [2:0]
	{
		// No strobe accepted this cycle
		REQ_NONE,
		// Memory read, starts a full read frame
		REQ_READ,
		// Control write with bit 8 low, sends one byte
		REQ_USER_BYTE,
		// Control write with bit 8 high, leaves user mode
		REQ_CFG_RELEASE,
		// Anything else, answered on the next edge
		REQ_IMMEDIATE
	} req_kind_e;

	typedef struct packed
	{
		req_kind_e kind;
		// Low byte of the write data, valid with REQ_USER_BYTE
		logic [USER_BYTE_W-1:0] user_byte;
	} bus_req_t;

endpackage

// File: source/flash_ctrl.sv
// Low logic serial flash read controller
// Bus reads fetch one 32 bit word with the 03h read command
// Control port gives software byte access to the flash

`timescale 1ns/1ps

module flash_ctrl
	import flash_spi_pkg::*;
	import flash_bus_pkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_reset,
	// Bus slave port
	input  logic                   i_wb_cyc,
	input  logic                   i_wb_stb,
	input  logic                   i_cfg_stb,
	input  logic                   i_wb_we,
	input  logic [WORD_ADDR_W-1:0] i_wb_addr,
	input  logic [DATA_W-1:0]      i_wb_data,
	output logic                   o_wb_stall,
	output logic                   o_wb_ack,
	output logic [DATA_W-1:0]      o_wb_data,
	// Flash pins
	output spi_pins_t              o_spi,
	input  logic                   i_spi_miso
);

	// Decoded request, valid in the accepting cycle only
	bus_req_t req;
	logic user_mode;
	logic cs_n;
	logic sck;
	logic mosi;
	// Returned bit valid
	logic sample;

	flash_request_decode u_decode (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_wb_stb    (i_wb_stb),
		.i_cfg_stb   (i_cfg_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_data   (i_wb_data),
		.i_stall     (o_wb_stall),
		.o_req       (req),
		.o_user_mode (user_mode)
	);

	flash_frame_sequencer u_sequencer (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_wb_cyc    (i_wb_cyc),
		.i_req       (req),
		.i_user_mode (user_mode),
		.o_stall     (o_wb_stall),
		.o_ack       (o_wb_ack),
		.o_cs_n      (cs_n),
		.o_sck       (sck),
		.o_sample    (sample)
	);

	flash_mosi_shifter u_mosi (
		.i_clk   (i_clk),
		.i_stall (o_wb_stall),
		.i_addr  (i_wb_addr),
		.i_req   (req),
		.o_mosi  (mosi)
	);

	flash_miso_capture u_miso (
		.i_clk       (i_clk),
		.i_sample    (sample),
		.i_user_mode (user_mode),
		.i_miso      (i_spi_miso),
		.o_data      (o_wb_data)
	);

	// Pin bundle toward the flash
	assign o_spi.cs_n = cs_n;
	assign o_spi.sck = sck;
	assign o_spi.mosi = mosi;

endmodule

// File: source/flash_frame_sequencer.sv
// Frame sequencer for the flash read controller
// Counts out each serial frame and derives stall, ack,
// chip select and the serial clock from the countdown

`timescale 1ns/1ps

module flash_frame_sequencer
	import flash_spi_pkg::*;
	import flash_bus_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_reset,
	input  logic     i_wb_cyc,
	input  bus_req_t i_req,
	input  logic     i_user_mode,
	output logic     o_stall,
	output logic     o_ack,
	output logic     o_cs_n,
	output logic     o_sck,
	output logic     o_sample
);

	// Cycles left in the current frame, zero when idle
	logic [FRAME_CNT_W-1:0] frame_cnt;
	// Request that starts a serial frame
	logic frame_start;
	// Last cycle of the frame
	logic frame_last;
	// Accepted control write of either kind
	logic cfg_write;

	assign frame_start = (i_req.kind == REQ_READ) || (i_req.kind == REQ_USER_BYTE);
	assign frame_last = (frame_cnt == FRAME_CNT_W'(1));
	assign cfg_write = (i_req.kind == REQ_USER_BYTE) || (i_req.kind == REQ_CFG_RELEASE);

	////////////////////
	// Countdown
	////////////////////

	// Dropping the bus cycle aborts the frame at once
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			frame_cnt <= '0;
		else if (i_req.kind == REQ_READ)
			frame_cnt <= FRAME_CNT_W'(READ_FRAME_LEN);
		else if (i_req.kind == REQ_USER_BYTE)
			frame_cnt <= FRAME_CNT_W'(USER_FRAME_LEN);
		else if (frame_cnt != '0)
			frame_cnt <= frame_cnt - 1'b1;
	end

	////////////////////
	// Bus handshake
	////////////////////

	// Stall for the whole frame, drops together with the ack
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			o_stall <= 1'b0;
		else if (frame_start)
			o_stall <= 1'b1;
		else
			o_stall <= (frame_cnt > FRAME_CNT_W'(1));
	end

	// One cycle ack at the end of a frame, or right away for
	// requests that need no serial traffic
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_ack <= 1'b0;
		else if (frame_last)
			o_ack <= i_wb_cyc;
		else if ((i_req.kind == REQ_IMMEDIATE) || (i_req.kind == REQ_CFG_RELEASE))
			o_ack <= 1'b1;
		else
			o_ack <= 1'b0;
	end

	////////////////////
	// Chip select
	////////////////////

	// User mode keeps the flash selected between byte frames
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_cs_n <= 1'b1;
		else if (!i_wb_cyc && !i_user_mode)
			o_cs_n <= 1'b1;
		else if (i_req.kind == REQ_READ)
			o_cs_n <= 1'b0;
		// Release deselects, a user byte selects
		else if (cfg_write)
			o_cs_n <= (i_req.kind == REQ_CFG_RELEASE);
		else if (i_user_mode)
			o_cs_n <= 1'b0;
		else if (frame_last)
			o_cs_n <= 1'b1;
	end

	////////////////////
	// Serial clock
	////////////////////

	// Runs one cycle short of the frame so the last bit settles
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_sck <= 1'b0;
		else if (frame_start)
			o_sck <= 1'b1;
		else if (i_wb_cyc && (frame_cnt > FRAME_CNT_W'(2)))
			o_sck <= 1'b1;
		else
			o_sck <= 1'b0;
	end

	// Clock as seen at the pin, one cycle late
	// Returned data is valid while this is high
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			o_sample <= 1'b0;
		else
			o_sample <= o_sck;
	end

endmodule

// File: source/flash_miso_capture.sv
// Returned data capture for the flash read controller
// Builds the read word, or the control register image in user mode

`timescale 1ns/1ps

module flash_miso_capture import flash_bus_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_sample,
	input  logic              i_user_mode,
	input  logic              i_miso,
	output logic [DATA_W-1:0] o_data
);

	// Control register image around a received byte
	function automatic logic [DATA_W-1:0] ctrl_image(input logic [USER_BYTE_W-1:0] b);
		logic [DATA_W-1:0] img;
		img = '0;
		img[CTRL_FLAG_BIT] = 1'b1;
		img[USER_BYTE_W-1:0] = b;
		return img;
	endfunction

	////////////////////
	// Shift in
	////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_sample)
		begin
			// User mode keeps only the last byte under the flag
			if (i_user_mode)
				o_data <= ctrl_image({o_data[USER_BYTE_W-2:0], i_miso});
			else
				o_data <= {o_data[DATA_W-2:0], i_miso};
		end
		// Hold the image steady between user frames
		else if (i_user_mode)
		begin
			o_data <= ctrl_image(o_data[USER_BYTE_W-1:0]);
		end
	end

endmodule

// File: source/flash_mosi_shifter.sv
// Outgoing serial data for the flash read controller
// Loads opcode and address, or a user byte, and shifts it out top bit first

`timescale 1ns/1ps

module flash_mosi_shifter
	import flash_spi_pkg::*;
	import flash_bus_pkg::*;
(
	input  logic                   i_clk,
	input  logic                   i_stall,
	input  logic [WORD_ADDR_W-1:0] i_addr,
	input  bus_req_t               i_req,
	output logic                   o_mosi
);

	// Idle bit, then 8 command bits, then 24 address bits
	logic [SHIFT_W-1:0] shift_q;

	////////////////////
	// Load and shift
	////////////////////

	// Loads every idle cycle so the word is ready on acceptance
	// Byte address is the word address with two zero bits below it
	always_ff @(posedge i_clk)
	begin
		if (!i_stall)
		begin
			if (i_req.kind == REQ_USER_BYTE)
				shift_q <= {1'b0, i_req.user_byte, i_addr, 2'b00};
			else
				shift_q <= {1'b0, CMD_READ, i_addr, 2'b00};
		end
		// One bit per cycle during the frame
		else
		begin
			shift_q <= {shift_q[SHIFT_W-2:0], 1'b0};
		end
	end

	// Top bit goes to the pin
	assign o_mosi = shift_q[SHIFT_W-1];

endmodule

// File: source/flash_request_decode.sv
// Request decode for the flash read controller
// Sorts every accepted strobe into one request kind
// and keeps the user mode flag

`timescale 1ns/1ps

module flash_request_decode import flash_bus_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_wb_stb,
	input  logic              i_cfg_stb,
	input  logic              i_wb_we,
	input  logic [DATA_W-1:0] i_wb_data,
	input  logic              i_stall,
	output bus_req_t          o_req,
	output logic              o_user_mode
);

	// A strobe only counts while the sequencer is not stalling
	logic accepted;
	// Accepted write to the control port
	logic cfg_write;

	assign accepted = (i_wb_stb || i_cfg_stb) && !i_stall;
	assign cfg_write = accepted && i_cfg_stb && i_wb_we;

	////////////////////
	// Request kind
	////////////////////

	always_comb
	begin
		o_req.user_byte = i_wb_data[USER_BYTE_W-1:0];
		if (!accepted)
			o_req.kind = REQ_NONE;
		// Memory read, but only when software does not own the bus
		else if (i_wb_stb && !i_wb_we && !o_user_mode)
			o_req.kind = REQ_READ;
		else if (cfg_write && !i_wb_data[CTRL_CS_BIT])
			o_req.kind = REQ_USER_BYTE;
		else if (cfg_write)
			o_req.kind = REQ_CFG_RELEASE;
		// Memory writes, control reads and reads in user mode
		else
			o_req.kind = REQ_IMMEDIATE;
	end

	////////////////////
	// User mode flag
	////////////////////

	// Any control write decides the mode
	// Bit 8 low enters user mode, bit 8 high leaves it
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_user_mode <= 1'b0;
		else if (cfg_write)
			o_user_mode <= !i_wb_data[CTRL_CS_BIT];
	end

endmodule

// File: source/flash_spi_pkg.sv
// Serial flash pin side definitions
// Read opcode, frame lengths, shift register width and the pin bundle

package flash_spi_pkg;

	////////////////////
	// Flash opcodes
	////////////////////

	// Plain read command, no dummy cycles
	// Limits the serial clock to what the slow read allows
	typedef enum logic [7:0]
	{
		CMD_READ = 8'h03
	} flash_cmd_e;

	////////////////////
	// Frame timing
	////////////////////

	// Read frame is 1 idle + 8 opcode + 24 address + 32 data bits
	localparam int READ_FRAME_LEN = 65;
	// User frame is 1 idle + 8 data bits
	localparam int USER_FRAME_LEN = 9;
	// Countdown must hold READ_FRAME_LEN
	localparam int FRAME_CNT_W = 7;

	// Outgoing shift register
	// Idle bit on top, then opcode, then byte address
	localparam int SHIFT_W = 33;

	////////////////////
	// Pin bundle
	////////////////////

	typedef struct packed
	{
		// Chip select, active low
		logic cs_n;
		// Serial clock, idles low
		logic sck;
		// Data toward the flash
		logic mosi;
	} spi_pins_t;

endpackage

// File: verilog.f
source/flash_spi_pkg.sv
source/flash_bus_pkg.sv
source/flash_request_decode.sv
source/flash_frame_sequencer.sv
source/flash_mosi_shifter.sv
source/flash_miso_capture.sv
source/flash_ctrl.sv
sim/flash_ctrl_asserts.sv
sim/flash_ctrl_tb.sv
